//--- bench/tb_arcade_input.sv
// Self-checking bench; cab is compared at every falling edge against a model one clock behind
`include "arcade_input_consts.svh"

module tb_arcade_input;
    timeunit 1ns;
    timeprecision 100ps;

    logic                              clk_sys = 1'b0;
    logic                              reset;
    arcade_input_pkg::ps2_event_t      ps2;
    arcade_input_pkg::dl_write_t       dl;
    logic [15:0]                       joy0;
    logic [15:0]                       joy1;
    logic [15:0]                       joy2;
    logic [15:0]                       joy3;
    arcade_input_pkg::cabinet_inputs_t cab;

    arcade_input_pkg::key_state_t      model_keys;
    logic [2:0][7:0]                   model_dips;
    logic                              model_toggle;
    arcade_input_pkg::cabinet_inputs_t exp_cab;
    logic                              have_expected = 1'b0;
    int                                checks = 0;
    logic [15:0]                       lfsr_state = 16'd48;
    logic [7:0]                        key_codes [17] = '{
        `ARC_KEY_START1, `ARC_KEY_START2, `ARC_KEY_COIN1, `ARC_KEY_COIN2,
        `ARC_KEY_P1_UP, `ARC_KEY_P1_DOWN, `ARC_KEY_P1_LEFT, `ARC_KEY_P1_RIGHT,
        `ARC_KEY_P1_A, `ARC_KEY_P1_B, `ARC_KEY_P2_UP, `ARC_KEY_P2_DOWN,
        `ARC_KEY_P2_LEFT, `ARC_KEY_P2_RIGHT, `ARC_KEY_P2_A, `ARC_KEY_P2_B, `ARC_KEY_PAUSE
    };

    arcade_input_top uut (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ps2     (ps2),
        .dl      (dl),
        .joy0    (joy0),
        .joy1    (joy1),
        .joy2    (joy2),
        .joy3    (joy3),
        .cab     (cab)
    );

    initial begin
        forever #4 clk_sys = ~clk_sys;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic nb;
        nb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], nb};
        return nb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            abort_run("Mismatch on DUT output");
        end
    endtask

    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    // Waits until the comparator has made n more checks
    task automatic wait_checks(input int n);
        int target;
        int cycles;
        target = checks + n;
        cycles = 0;
        while (checks < target && cycles < n + 20) begin
            @(posedge clk_sys);
            cycles++;
        end
        if (checks < target) begin
            abort_run("Timeout: comparator stopped making checks");
        end
        #1;
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Arrows ignore the E0 flag, everything else needs it clear
    function automatic arcade_input_pkg::key_state_t apply_key_event(
        input arcade_input_pkg::key_state_t k, input arcade_input_pkg::ps2_event_t ev
    );
        logic plain;
        plain = ~ev.extended;
        case (ev.code)
            `ARC_KEY_P1_UP:    k.p1_up = ev.pressed;
            `ARC_KEY_P1_DOWN:  k.p1_down = ev.pressed;
            `ARC_KEY_P1_LEFT:  k.p1_left = ev.pressed;
            `ARC_KEY_P1_RIGHT: k.p1_right = ev.pressed;
            `ARC_KEY_START1:   if (plain) k.start1 = ev.pressed;
            `ARC_KEY_START2:   if (plain) k.start2 = ev.pressed;
            `ARC_KEY_COIN1:    if (plain) k.coin1 = ev.pressed;
            `ARC_KEY_COIN2:    if (plain) k.coin2 = ev.pressed;
            `ARC_KEY_P1_A:     if (plain) k.p1_a = ev.pressed;
            `ARC_KEY_P1_B:     if (plain) k.p1_b = ev.pressed;
            `ARC_KEY_P2_UP:    if (plain) k.p2_up = ev.pressed;
            `ARC_KEY_P2_DOWN:  if (plain) k.p2_down = ev.pressed;
            `ARC_KEY_P2_LEFT:  if (plain) k.p2_left = ev.pressed;
            `ARC_KEY_P2_RIGHT: if (plain) k.p2_right = ev.pressed;
            `ARC_KEY_P2_A:     if (plain) k.p2_a = ev.pressed;
            `ARC_KEY_P2_B:     if (plain) k.p2_b = ev.pressed;
            `ARC_KEY_PAUSE:    if (plain) k.pause = ev.pressed;
            default:           k = k;
        endcase
        return k;
    endfunction

    function automatic arcade_input_pkg::cabinet_inputs_t expected_cab(
        input arcade_input_pkg::key_state_t k, input logic [2:0][7:0] d,
        input logic [15:0] j0, input logic [15:0] j1, input logic [15:0] j2, input logic [15:0] j3
    );
        arcade_input_pkg::cabinet_inputs_t c;
        logic [15:0]                       all;
        all = j0 | j1 | j2 | j3;
        // Byte order a b x y up down left right
        c.p1 = {j0[4], j0[5], j0[6], j0[7], j0[3], j0[2], j0[1], j0[0]}
             | {k.p1_a, k.p1_b, 2'b00, k.p1_up, k.p1_down, k.p1_left, k.p1_right};
        c.p2 = {j1[4], j1[5], j1[6], j1[7], j1[3], j1[2], j1[1], j1[0]}
             | {k.p2_a, k.p2_b, 2'b00, k.p2_up, k.p2_down, k.p2_left, k.p2_right};
        c.p3 = {j2[4], j2[5], j2[6], j2[7], j2[3], j2[2], j2[1], j2[0]};
        c.p4 = {j3[4], j3[5], j3[6], j3[7], j3[3], j3[2], j3[1], j3[0]};
        c.start1 = j0[8] | k.start1;
        c.start2 = j1[8] | all[10] | k.start2;
        c.coin   = all[9] | k.coin1 | k.coin2;
        c.pause  = all[11] | k.pause;
        c.dip0   = d[0];
        c.dip1   = d[1];
        c.dip2   = d[2];
        return c;
    endfunction

    // Inputs seen at this falling edge are sampled by the next rising edge
    always @(negedge clk_sys) begin
        if (have_expected) begin
            check_value("cab", cab, exp_cab);
            checks++;
        end
        if (reset) begin
            model_keys   = '0;
            model_dips   = {3{8'hFF}};
            model_toggle = 1'b0;
            exp_cab      = '0;
            exp_cab.dip0 = 8'hFF;
            exp_cab.dip1 = 8'hFF;
            exp_cab.dip2 = 8'hFF;
        end else begin
            exp_cab = expected_cab(model_keys, model_dips, joy0, joy1, joy2, joy3);
            if (ps2.toggle != model_toggle) begin
                model_keys = apply_key_event(model_keys, ps2);
            end
            model_toggle = ps2.toggle;
            if (dl.wr && dl.index == `ARC_DL_INDEX_DIP && dl.addr < `ARC_DIP_BYTES) begin
                model_dips[dl.addr[1:0]] = dl.data;
            end
        end
        have_expected = 1'b1;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic key_event(input logic [7:0] code, input logic pressed,
                             input logic extended, input logic flip);
        step();
        ps2.toggle   = ps2.toggle ^ flip;
        ps2.pressed  = pressed;
        ps2.extended = extended;
        ps2.code     = code;
    endtask

    task automatic dip_write(input logic [7:0] index, input logic [23:0] addr,
                             input logic [7:0] data);
        step();
        dl = '{wr: 1'b1, index: index, addr: addr, data: data};
        step();
        dl.wr = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        ps2   = '0;
        dl    = '0;
        joy0  = '0;
        joy1  = '0;
        joy2  = '0;
        joy3  = '0;
        repeat (4) @(posedge clk_sys);
        #1;
        reset = 1'b0;
        wait_checks(2);
        check_value("cab_after_reset", cab, {36'b0, 24'hFFFFFF});

        // Joysticks alone
        for (int i = 0; i < 40; i++) begin
            step();
            joy0 = rand_bits(16);
            joy1 = rand_bits(16);
            joy2 = rand_bits(16);
            joy3 = rand_bits(16);
        end
        step();
        {joy0, joy1, joy2, joy3} = '0;

        // Every table key pressed and released, arrows also with E0
        for (int i = 0; i < 17; i++) begin
            key_event(key_codes[i], 1'b1, 1'b0, 1'b1);
            key_event(key_codes[i], 1'b0, 1'b0, 1'b1);
            key_event(key_codes[i], 1'b1, 1'b1, 1'b1);
            key_event(key_codes[i], 1'b0, 1'b1, 1'b1);
        end
        key_event(`ARC_KEY_START1, 1'b1, 1'b0, 1'b1);
        wait_checks(2);
        check_value("cab.start1", cab.start1, 1'b1);
        key_event(`ARC_KEY_START1, 1'b0, 1'b0, 1'b0);
        key_event(8'h5A, 1'b1, 1'b0, 1'b1);
        wait_checks(2);
        check_value("cab.start1_held", cab.start1, 1'b1);

        // DIP bytes, then writes that must be dropped
        for (int n = 0; n < 3; n++) begin
            dip_write(`ARC_DL_INDEX_DIP, 24'(n), rand_bits(8));
        end
        dip_write(8'd253, 24'd0, 8'h00);
        dip_write(`ARC_DL_INDEX_DIP, 24'd3, 8'h00);
        dip_write(`ARC_DL_INDEX_DIP, 24'h000100, 8'h00);

        // Long random mix of all inputs
        for (int i = 0; i < 300; i++) begin
            step();
            ps2.toggle   = ps2.toggle ^ lfsr_step();
            ps2.pressed  = lfsr_step();
            ps2.extended = lfsr_step();
            ps2.code     = lfsr_step() ? key_codes[rand_bits(4)] : rand_bits(8);
            dl.wr        = lfsr_step();
            dl.index     = lfsr_step() ? `ARC_DL_INDEX_DIP : rand_bits(8);
            dl.addr      = 24'(rand_bits(2));
            dl.data      = rand_bits(8);
            if (lfsr_step()) begin
                joy0 = rand_bits(16);
                joy1 = rand_bits(16);
                joy2 = rand_bits(16);
                joy3 = rand_bits(16);
            end
        end
        wait_checks(3);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- common/arcade_input_consts.svh
// Scan codes are set 2 make codes without the E0 prefix; the download index and DIP count are core-specific
`ifndef ARC_INPUT_CONSTS_SVH
`define ARC_INPUT_CONSTS_SVH

//////////////////////////////
// Download port
//////////////////////////////

// Index that carries DIP switch bytes
`define ARC_DL_INDEX_DIP 8'd254

// Number of DIP bytes the core reads
`define ARC_DIP_BYTES 3

//////////////////////////////
// Keyboard scan codes
//////////////////////////////

// Cabinet keys: 1, 2, 5, 6
`define ARC_KEY_START1   8'h16
`define ARC_KEY_START2   8'h1E
`define ARC_KEY_COIN1    8'h2E
`define ARC_KEY_COIN2    8'h36

// Player 1 arrows, matched with or without the extended prefix
`define ARC_KEY_P1_UP    8'h75
`define ARC_KEY_P1_DOWN  8'h72
`define ARC_KEY_P1_LEFT  8'h6B
`define ARC_KEY_P1_RIGHT 8'h74

// Player 1 buttons: left ctrl, left alt
`define ARC_KEY_P1_A     8'h14
`define ARC_KEY_P1_B     8'h11

// Player 2 on R, F, D, G with A and S as buttons
`define ARC_KEY_P2_UP    8'h2D
`define ARC_KEY_P2_DOWN  8'h2B
`define ARC_KEY_P2_LEFT  8'h23
`define ARC_KEY_P2_RIGHT 8'h34
`define ARC_KEY_P2_A     8'h1C
`define ARC_KEY_P2_B     8'h1B

`define ARC_KEY_PAUSE    8'h4D

//////////////////////////////
// Joystick word bit positions
//////////////////////////////

`define ARC_JOY_START    8
`define ARC_JOY_COIN     9
`define ARC_JOY_START2   10
`define ARC_JOY_PAUSE    11

`endif

//--- common/arcade_input_pkg.sv
// Struct field order is the bit order, first field at the MSB; DIP bytes are active low
package arcade_input_pkg;

    //////////////////////////////
    // Keyboard
    //////////////////////////////

    // One keyboard event, toggle flips on every new event
    typedef struct packed {
        logic       toggle;
        logic       pressed;
        logic       extended;
        logic [7:0] code;
    } ps2_event_t;

    // Keys currently held down
    typedef struct packed {
        logic p1_up;
        logic p1_down;
        logic p1_left;
        logic p1_right;
        logic p1_a;
        logic p1_b;
        logic p2_up;
        logic p2_down;
        logic p2_left;
        logic p2_right;
        logic p2_a;
        logic p2_b;
        logic start1;
        logic start2;
        logic coin1;
        logic coin2;
        logic pause;
    } key_state_t;

    //////////////////////////////
    // Download port
    //////////////////////////////

    // Single-cycle write from the loader
    typedef struct packed {
        logic        wr;
        logic [7:0]  index;
        logic [23:0] addr;
        logic [7:0]  data;
    } dl_write_t;

    //////////////////////////////
    // Cabinet side
    //////////////////////////////

    // Player byte in the layout the game board expects
    typedef struct packed {
        logic a;
        logic b;
        logic x;
        logic y;
        logic up;
        logic down;
        logic left;
        logic right;
    } player_input_t;

    typedef struct packed {
        player_input_t p1;
        player_input_t p2;
        player_input_t p3;
        player_input_t p4;
        logic          start1;
        logic          start2;
        logic          coin;
        logic          pause;
        logic [7:0]    dip0;
        logic [7:0]    dip1;
        logic [7:0]    dip2;
    } cabinet_inputs_t;

endpackage

//--- rtl/arcade_input_top.sv
// Key events and DIP writes reach cab after two clocks, joystick changes after one
`include "arcade_input_consts.svh"

module arcade_input_top (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  arcade_input_pkg::ps2_event_t      ps2,
    input  arcade_input_pkg::dl_write_t       dl,
    input  logic [15:0]                       joy0,
    input  logic [15:0]                       joy1,
    input  logic [15:0]                       joy2,
    input  logic [15:0]                       joy3,
    output arcade_input_pkg::cabinet_inputs_t cab
);

    arcade_input_pkg::key_state_t   keys;
    logic [`ARC_DIP_BYTES-1:0][7:0] dips;

    //////////////////////////////
    // Keyboard and DIP sources
    //////////////////////////////

    key_decoder u_key_decoder (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ps2     (ps2),
        .keys    (keys)
    );

    dip_capture u_dip_capture (
        .clk_sys (clk_sys),
        .reset   (reset),
        .dl      (dl),
        .dips    (dips)
    );

    //////////////////////////////
    // Merge into the cabinet word
    //////////////////////////////

    input_combiner u_input_combiner (
        .clk_sys (clk_sys),
        .reset   (reset),
        .joy0    (joy0),
        .joy1    (joy1),
        .joy2    (joy2),
        .joy3    (joy3),
        .keys    (keys),
        .dips    (dips),
        .cab     (cab)
    );

endmodule

//--- rtl/dip_capture.sv
// Only the first ARC_DIP_BYTES bytes of the DIP download are kept; bytes reset to all switches off
`include "arcade_input_consts.svh"

module dip_capture (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  arcade_input_pkg::dl_write_t       dl,
    output logic [`ARC_DIP_BYTES-1:0][7:0]    dips
);

    logic dip_write;

    // Write strobe qualified by the DIP download index
    assign dip_write = dl.wr && (dl.index == `ARC_DL_INDEX_DIP);

    //////////////////////////////
    // DIP byte slots
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            // Active low, so FF means every switch off
            for (int n = 0; n < `ARC_DIP_BYTES; n++) begin
                dips[n] <= 8'hFF;
            end
        end else if (dip_write) begin
            // Addresses past the last slot fall through unmatched
            for (int n = 0; n < `ARC_DIP_BYTES; n++) begin
                if (dl.addr == 24'(n)) begin
                    dips[n] <= dl.data;
                end
            end
        end
    end

endmodule

//--- rtl/input_combiner.sv
// Joystick words use the usual core layout: bits 0 to 7 are R, L, D, U, A, B, X, Y
`include "arcade_input_consts.svh"

module input_combiner (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic [15:0]                       joy0,
    input  logic [15:0]                       joy1,
    input  logic [15:0]                       joy2,
    input  logic [15:0]                       joy3,
    input  arcade_input_pkg::key_state_t      keys,
    input  logic [`ARC_DIP_BYTES-1:0][7:0]    dips,
    output arcade_input_pkg::cabinet_inputs_t cab
);

    logic [15:0]                       joy_all;
    arcade_input_pkg::player_input_t   p1;
    arcade_input_pkg::player_input_t   p2;
    arcade_input_pkg::cabinet_inputs_t cab_next;

    // Reorder a joystick word into the board's player byte
    function automatic arcade_input_pkg::player_input_t joy_to_player(
        input logic [15:0] joy
    );
        arcade_input_pkg::player_input_t p;
        p.a     = joy[4];
        p.b     = joy[5];
        p.x     = joy[6];
        p.y     = joy[7];
        p.up    = joy[3];
        p.down  = joy[2];
        p.left  = joy[1];
        p.right = joy[0];
        return p;
    endfunction

    // Start2, coin and pause can come from any pad
    assign joy_all = joy0 | joy1 | joy2 | joy3;

    //////////////////////////////
    // Player bytes with keys merged
    //////////////////////////////

    always_comb begin
        p1       = joy_to_player(joy0);
        p1.a     = p1.a | keys.p1_a;
        p1.b     = p1.b | keys.p1_b;
        p1.up    = p1.up | keys.p1_up;
        p1.down  = p1.down | keys.p1_down;
        p1.left  = p1.left | keys.p1_left;
        p1.right = p1.right | keys.p1_right;

        p2       = joy_to_player(joy1);
        p2.a     = p2.a | keys.p2_a;
        p2.b     = p2.b | keys.p2_b;
        p2.up    = p2.up | keys.p2_up;
        p2.down  = p2.down | keys.p2_down;
        p2.left  = p2.left | keys.p2_left;
        p2.right = p2.right | keys.p2_right;
    end

    //////////////////////////////
    // Cabinet word
    //////////////////////////////

    always_comb begin
        cab_next.p1     = p1;
        cab_next.p2     = p2;
        cab_next.p3     = joy_to_player(joy2);
        cab_next.p4     = joy_to_player(joy3);
        cab_next.start1 = joy0[`ARC_JOY_START] | keys.start1;
        cab_next.start2 = joy1[`ARC_JOY_START] | joy_all[`ARC_JOY_START2] | keys.start2;
        // Both coin keys feed the one coin slot
        cab_next.coin   = joy_all[`ARC_JOY_COIN] | keys.coin1 | keys.coin2;
        cab_next.pause  = joy_all[`ARC_JOY_PAUSE] | keys.pause;
        cab_next.dip0   = dips[0];
        cab_next.dip1   = dips[1];
        cab_next.dip2   = dips[2];
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cab      <= '0;
            cab.dip0 <= 8'hFF;
            cab.dip1 <= 8'hFF;
            cab.dip2 <= 8'hFF;
        end else begin
            cab <= cab_next;
        end
    end

endmodule

//--- rtl/key_decoder.sv
// Expects a level event word whose toggle flips once per event; keys held across reset are lost
`include "arcade_input_consts.svh"

module key_decoder (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  arcade_input_pkg::ps2_event_t ps2,
    output arcade_input_pkg::key_state_t keys
);

    logic                         prev_toggle;
    logic                         new_event;
    logic                         plain;
    arcade_input_pkg::key_state_t hit;

    // A new event is signalled by the toggle changing
    assign new_event = ps2.toggle ^ prev_toggle;

    //////////////////////////////
    // Scan code table
    //////////////////////////////

    always_comb begin
        hit   = '0;
        // Non-arrow keys only match without the E0 prefix
        plain = ~ps2.extended;
        case (ps2.code)
            `ARC_KEY_START1: begin
                hit.start1 = plain;
            end
            `ARC_KEY_START2: begin
                hit.start2 = plain;
            end
            `ARC_KEY_COIN1: begin
                hit.coin1 = plain;
            end
            `ARC_KEY_COIN2: begin
                hit.coin2 = plain;
            end
            // Arrows come from both the cursor block and the keypad
            `ARC_KEY_P1_UP: begin
                hit.p1_up = 1'b1;
            end
            `ARC_KEY_P1_DOWN: begin
                hit.p1_down = 1'b1;
            end
            `ARC_KEY_P1_LEFT: begin
                hit.p1_left = 1'b1;
            end
            `ARC_KEY_P1_RIGHT: begin
                hit.p1_right = 1'b1;
            end
            `ARC_KEY_P1_A: begin
                hit.p1_a = plain;
            end
            `ARC_KEY_P1_B: begin
                hit.p1_b = plain;
            end
            `ARC_KEY_P2_UP: begin
                hit.p2_up = plain;
            end
            `ARC_KEY_P2_DOWN: begin
                hit.p2_down = plain;
            end
            `ARC_KEY_P2_LEFT: begin
                hit.p2_left = plain;
            end
            `ARC_KEY_P2_RIGHT: begin
                hit.p2_right = plain;
            end
            `ARC_KEY_P2_A: begin
                hit.p2_a = plain;
            end
            `ARC_KEY_P2_B: begin
                hit.p2_b = plain;
            end
            `ARC_KEY_PAUSE: begin
                hit.pause = plain;
            end
            default: begin
                hit = '0;
            end
        endcase
    end

    //////////////////////////////
    // Held key flags
    //////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prev_toggle <= 1'b0;
            keys        <= '0;
        end else begin
            prev_toggle <= ps2.toggle;
            // Only the matched flag takes the pressed state
            if (new_event) begin
                keys <= (keys & ~hit) | (hit & {$bits(hit){ps2.pressed}});
            end
        end
    end

endmodule

//--- tb.f
+incdir+common
common/arcade_input_pkg.sv
rtl/key_decoder.sv
rtl/dip_capture.sv
rtl/input_combiner.sv
rtl/arcade_input_top.sv
bench/tb_arcade_input.sv
